/* common/bridge_pkg.sv */
package bridge_pkg;

   // byte side and word side of the bridge
   localparam int BYTE_W = 8;
   localparam int WORD_W = 32;

   // fifo depth in bytes is 2**ADDR_W
   localparam int ADDR_W = 6;
   localparam int LEVEL_W = ADDR_W + 1;

   // drop and word counters
   localparam int COUNT_W = 16;

   // ratio of the wider port width to the narrower one
   function automatic int width_ratio(input int a_w, input int b_w);
      return (a_w > b_w) ? a_w / b_w : b_w / a_w;
   endfunction

   // address width of a port counted in its own data units
   // the wide port needs fewer bits than the narrow one
   function automatic int port_addr_w(input int own_w, input int other_w,
                                      input int addr_w);
      if (own_w > other_w) begin
         return addr_w - $clog2(width_ratio(own_w, other_w));
      end
      return addr_w;
   endfunction

endpackage

/* fifo/fifo_sync_asym.sv */
`timescale 1ns/1ps

module fifo_sync_asym #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W = 6
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   output logic                w_full,
   input  logic                r_en,
   output logic [R_DATA_W-1:0] r_data,
   output logic                r_empty,
   output logic [ADDR_W:0]     level
);

   localparam int W_ADDR_W = bridge_pkg::port_addr_w(W_DATA_W, R_DATA_W, ADDR_W);
   localparam int R_ADDR_W = bridge_pkg::port_addr_w(R_DATA_W, W_DATA_W, ADDR_W);
   localparam int RATIO = bridge_pkg::width_ratio(W_DATA_W, R_DATA_W);

   // capacity counted in narrow units
   localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W + 1)'(1) << ADDR_W;

   // level step per access, the wide side moves RATIO narrow units
   localparam logic [ADDR_W:0] W_INCR = (W_DATA_W > R_DATA_W) ? (ADDR_W + 1)'(RATIO) : 1;
   localparam logic [ADDR_W:0] R_INCR = (R_DATA_W > W_DATA_W) ? (ADDR_W + 1)'(RATIO) : 1;

   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   logic [ADDR_W:0]     level_nxt;

   // address counters wrap around the memory
   always_ff @(posedge clk) begin
      if (reset) begin
         w_addr <= '0;
      end else if (w_en) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         r_addr <= '0;
      end else if (r_en) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   always_comb begin
      level_nxt = level;
      case ({w_en, r_en})
         2'b10:   level_nxt = level + W_INCR;
         2'b01:   level_nxt = level - R_INCR;
         2'b11:   level_nxt = level + W_INCR - R_INCR;
         default: level_nxt = level;
      endcase
   end

   // flags follow the next level so they agree with level every cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         level   <= '0;
         r_empty <= 1'b1;
         w_full  <= 1'b0;
      end else begin
         level   <= level_nxt;
         r_empty <= level_nxt < R_INCR;
         w_full  <= level_nxt > (FIFO_SIZE - W_INCR);
      end
   end

   ram_2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) ram_2p_asym_inst (
      .clk    (clk),
      .w_en   (w_en),
      .w_addr (w_addr),
      .w_data (w_data),
      .r_en   (r_en),
      .r_addr (r_addr),
      .r_data (r_data)
   );

endmodule

/* fifo/ram_2p_asym.sv */
`timescale 1ns/1ps

module ram_2p_asym #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W = 6,
   localparam int W_ADDR_W = bridge_pkg::port_addr_w(W_DATA_W, R_DATA_W, ADDR_W),
   localparam int R_ADDR_W = bridge_pkg::port_addr_w(R_DATA_W, W_DATA_W, ADDR_W)
) (
   input  logic                clk,
   input  logic                w_en,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic [W_DATA_W-1:0] w_data,
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   localparam int MAX_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MIN_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;
   localparam int LANE_W = $clog2(bridge_pkg::width_ratio(W_DATA_W, R_DATA_W));
   localparam int ROW_ADDR_W = ADDR_W - LANE_W;

   // storage is kept as rows of the wider width
   logic [MAX_W-1:0] mem [2**ROW_ADDR_W];

   generate
      if (W_DATA_W < R_DATA_W) begin : g_narrow_write
         // row from the upper address bits, lane from the lower ones
         always_ff @(posedge clk) begin
            if (w_en) begin
               mem[w_addr[ADDR_W-1:LANE_W]][w_addr[LANE_W-1:0]*MIN_W +: MIN_W] <= w_data;
            end
         end

         always_ff @(posedge clk) begin
            if (r_en) begin
               r_data <= mem[r_addr];
            end
         end
      end else if (W_DATA_W > R_DATA_W) begin : g_narrow_read
         logic [MAX_W-1:0]  row_q;
         logic [LANE_W-1:0] lane_q;

         always_ff @(posedge clk) begin
            if (w_en) begin
               mem[w_addr] <= w_data;
            end
         end

         // whole row registered, lane picked after the register
         always_ff @(posedge clk) begin
            if (r_en) begin
               row_q  <= mem[r_addr[ADDR_W-1:LANE_W]];
               lane_q <= r_addr[LANE_W-1:0];
            end
         end

         assign r_data = row_q[lane_q*MIN_W +: MIN_W];
      end else begin : g_symmetric
         always_ff @(posedge clk) begin
            if (w_en) begin
               mem[w_addr] <= w_data;
            end
            if (r_en) begin
               r_data <= mem[r_addr];
            end
         end
      end
   endgenerate

endmodule

/* hdl/byte_ingress.sv */
`timescale 1ns/1ps

module byte_ingress (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          byte_valid,
   input  logic [bridge_pkg::BYTE_W-1:0] byte_data,
   input  logic                          w_full,
   output logic                          w_en,
   output logic [bridge_pkg::BYTE_W-1:0] w_data,
   output logic [bridge_pkg::COUNT_W-1:0] drop_count
);

   logic                          valid_q;
   logic [bridge_pkg::BYTE_W-1:0] data_q;
   logic                          drop;

   // input stage for the byte strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= byte_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (byte_valid) begin
         data_q <= byte_data;
      end
   end

   // write only when there is room, else the byte is lost
   assign w_en   = valid_q & ~w_full;
   assign w_data = data_q;
   assign drop   = valid_q & w_full;

   // drop counter sticks at its maximum
   always_ff @(posedge clk) begin
      if (reset) begin
         drop_count <= '0;
      end else if (drop && (drop_count != '1)) begin
         drop_count <= drop_count + 1'b1;
      end
   end

endmodule

/* hdl/byte_to_word_bridge.sv */
`timescale 1ns/1ps

module byte_to_word_bridge (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           byte_valid,
   input  logic [bridge_pkg::BYTE_W-1:0]  byte_data,
   input  logic                           word_take,
   output logic                           word_valid,
   output logic [bridge_pkg::WORD_W-1:0]  word_data,
   output logic [bridge_pkg::LEVEL_W-1:0] level,
   output logic [bridge_pkg::COUNT_W-1:0] drop_count,
   output logic [bridge_pkg::COUNT_W-1:0] word_count
);

   // ingress to fifo
   logic                          w_en;
   logic [bridge_pkg::BYTE_W-1:0] w_data;
   logic                          w_full;

   // fifo to egress
   logic                          r_en;
   logic [bridge_pkg::WORD_W-1:0] r_data;
   logic                          r_empty;

   byte_ingress byte_ingress_inst (
      .clk        (clk),
      .reset      (reset),
      .byte_valid (byte_valid),
      .byte_data  (byte_data),
      .w_full     (w_full),
      .w_en       (w_en),
      .w_data     (w_data),
      .drop_count (drop_count)
   );

   // bytes in, words out, first byte ends up lowest
   fifo_sync_asym #(
      .W_DATA_W (bridge_pkg::BYTE_W),
      .R_DATA_W (bridge_pkg::WORD_W),
      .ADDR_W   (bridge_pkg::ADDR_W)
   ) fifo_sync_asym_inst (
      .clk     (clk),
      .reset   (reset),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_full  (w_full),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_empty (r_empty),
      .level   (level)
   );

   word_egress word_egress_inst (
      .clk        (clk),
      .reset      (reset),
      .word_take  (word_take),
      .r_empty    (r_empty),
      .r_en       (r_en),
      .r_data     (r_data),
      .word_valid (word_valid),
      .word_data  (word_data),
      .word_count (word_count)
   );

endmodule

/* hdl/word_egress.sv */
`timescale 1ns/1ps

module word_egress (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           word_take,
   input  logic                           r_empty,
   output logic                           r_en,
   input  logic [bridge_pkg::WORD_W-1:0]  r_data,
   output logic                           word_valid,
   output logic [bridge_pkg::WORD_W-1:0]  word_data,
   output logic [bridge_pkg::COUNT_W-1:0] word_count
);

   // pop whenever the sink allows and a whole word is stored
   assign r_en = word_take & ~r_empty;

   // ram output is registered, so valid trails the read by one cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         word_valid <= 1'b0;
      end else begin
         word_valid <= r_en;
      end
   end

   assign word_data = r_data;

   // delivered words, wraps around
   always_ff @(posedge clk) begin
      if (reset) begin
         word_count <= '0;
      end else if (word_valid) begin
         word_count <= word_count + 1'b1;
      end
   end

endmodule

/* project.f */
common/bridge_pkg.sv
fifo/ram_2p_asym.sv
fifo/fifo_sync_asym.sv
hdl/byte_ingress.sv
hdl/word_egress.sv
hdl/byte_to_word_bridge.sv
sim/bridge_tb.sv

/* run.sh */
#!/bin/sh
# build the bridge testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   -f project.f --top-module bridge_tb -o bridge_sim &&
   ./obj_dir/bridge_sim | tee /dev/stderr | grep -q "all tests passed" ||
   { echo "simulation failed"; exit 1; }

echo "simulation passed"

/* sim/bridge_tb.sv */
`timescale 1ns/1ps

module bridge_tb;

   localparam int FIFO_BYTES = 2 ** bridge_pkg::ADDR_W;
   localparam int WORD_BYTES = bridge_pkg::WORD_W / bridge_pkg::BYTE_W;
   localparam int COUNT_MAX = 2 ** bridge_pkg::COUNT_W - 1;
   localparam int RESET_CYCLES = 8;
   localparam int PACK_BYTES = 48;
   localparam int BP_BYTES = 80;
   localparam int RAND_CYCLES = 2000;
   localparam int DRAIN_LIMIT = 100;
   localparam int STIM_CYCLES = RESET_CYCLES + PACK_BYTES + BP_BYTES + RAND_CYCLES
                                + 3 * DRAIN_LIMIT;
   localparam int WATCHDOG_CYCLES = 2 * STIM_CYCLES + 1000;

   logic                           clk;
   logic                           reset;
   logic                           byte_valid;
   logic [bridge_pkg::BYTE_W-1:0]  byte_data;
   logic                           word_take;
   logic                           word_valid;
   logic [bridge_pkg::WORD_W-1:0]  word_data;
   logic [bridge_pkg::LEVEL_W-1:0] level;
   logic [bridge_pkg::COUNT_W-1:0] drop_count;
   logic [bridge_pkg::COUNT_W-1:0] word_count;

   // reference model state moves once per cycle at the falling edge
   logic [bridge_pkg::BYTE_W-1:0] stored_bytes[$];
   logic [bridge_pkg::WORD_W-1:0] exp_words[$];
   logic                          held_valid;
   logic [bridge_pkg::BYTE_W-1:0] held_data;
   logic                          rd_prev;
   int                            m_level;
   int                            m_drops;
   int                            accepted_total;
   int                            delivered_total;
   int                            idle_run;

   byte_to_word_bridge byte_to_word_bridge_inst (
      .clk        (clk),
      .reset      (reset),
      .byte_valid (byte_valid),
      .byte_data  (byte_data),
      .word_take  (word_take),
      .word_valid (word_valid),
      .word_data  (word_data),
      .level      (level),
      .drop_count (drop_count),
      .word_count (word_count)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic end_with_failure(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string what);
      end_with_failure($sformatf("error at %0t ns: %s", $time, what));
   endtask

   function automatic logic [bridge_pkg::BYTE_W-1:0] random_byte();
      logic [31:0] r;
      r = $urandom;
      return r[bridge_pkg::BYTE_W-1:0];
   endfunction

   level_in_range: assert property (@(posedge clk) disable iff (reset) level <= FIFO_BYTES)
      else report_mismatch($sformatf("level %0d beyond %0d bytes", level, FIFO_BYTES));

   // bridge model built from its timing rules
   // compares before it updates
   always @(negedge clk) begin
      logic                          full;
      logic                          empty;
      logic                          wr;
      logic                          rd;
      logic [bridge_pkg::WORD_W-1:0] word;
      if (reset) begin
         stored_bytes.delete();
         exp_words.delete();
         held_valid = 1'b0;
         held_data = '0;
         rd_prev = 1'b0;
         m_level = 0;
         m_drops = 0;
         accepted_total = 0;
         delivered_total = 0;
         idle_run = 0;
      end else begin
         assert (word_valid == rd_prev)
            else report_mismatch($sformatf("word_valid %0b, expected %0b", word_valid, rd_prev));
         if (word_valid && exp_words.size() > 0) begin
            word = exp_words.pop_front();
            assert (word_data == word)
               else report_mismatch($sformatf("word_data %08h, expected %08h", word_data, word));
         end
         assert (int'(word_count) == delivered_total % (COUNT_MAX + 1))
            else report_mismatch($sformatf("word_count %0d, expected %0d", word_count,
                                           delivered_total % (COUNT_MAX + 1)));
         assert (int'(drop_count) == m_drops)
            else report_mismatch($sformatf("drop_count %0d, expected %0d", drop_count, m_drops));
         // a word read last cycle is stored no more but not yet delivered
         if (idle_run >= 3) begin
            assert (int'(level) == accepted_total
                    - WORD_BYTES * (delivered_total + (rd_prev ? 1 : 0)))
               else report_mismatch($sformatf("level %0d after idle, accepted %0d delivered %0d",
                                              level, accepted_total, delivered_total));
         end
         if (word_valid) begin
            delivered_total++;
         end
         full  = m_level >= FIFO_BYTES;
         empty = m_level < WORD_BYTES;
         wr    = held_valid && !full;
         rd    = word_take && !empty;
         if (held_valid && full && m_drops < COUNT_MAX) begin
            m_drops++;
         end
         // first byte of a group goes to the low lane
         if (rd) begin
            for (int k = 0; k < WORD_BYTES; k++) begin
               word[k*bridge_pkg::BYTE_W +: bridge_pkg::BYTE_W] = stored_bytes.pop_front();
            end
            exp_words.push_back(word);
         end
         if (wr) begin
            stored_bytes.push_back(held_data);
            accepted_total++;
         end
         m_level = m_level + (wr ? 1 : 0) - (rd ? WORD_BYTES : 0);
         rd_prev = rd;
         held_valid = byte_valid;
         held_data = byte_data;
         idle_run = byte_valid ? 0 : idle_run + 1;
      end
   end

   task automatic strobe_byte(input logic [bridge_pkg::BYTE_W-1:0] value);
      @(posedge clk);
      byte_valid <= 1'b1;
      byte_data  <= value;
   endtask

   task automatic hold_idle(input int cycles);
      @(posedge clk);
      byte_valid <= 1'b0;
      repeat (cycles) @(posedge clk);
   endtask

   task automatic set_take(input logic value);
      @(posedge clk);
      byte_valid <= 1'b0;
      word_take  <= value;
   endtask

   task automatic wait_for_drain(input int limit);
      int waited;
      waited = 0;
      while (!(m_level < WORD_BYTES && exp_words.size() == 0 && idle_run >= 3)) begin
         @(posedge clk);
         waited++;
         if (waited > limit) begin
            end_with_failure($sformatf("timeout: fifo did not drain within %0d cycles", limit));
         end
      end
   endtask

   task automatic check_after_reset();
      @(negedge clk);
      assert (word_valid == 1'b0) else report_mismatch("word_valid high after reset");
      assert (level == '0) else report_mismatch($sformatf("level %0d after reset", level));
      assert (drop_count == '0)
         else report_mismatch($sformatf("drop_count %0d after reset", drop_count));
      assert (word_count == '0)
         else report_mismatch($sformatf("word_count %0d after reset", word_count));
   endtask

   task automatic run_packing();
      set_take(1'b1);
      for (int i = 0; i < PACK_BYTES; i++) begin
         strobe_byte(random_byte());
      end
      hold_idle(3);
      wait_for_drain(DRAIN_LIMIT);
   endtask

   task automatic run_back_pressure();
      int drops_before;
      int words_before;
      drops_before = m_drops;
      set_take(1'b0);
      for (int i = 0; i < BP_BYTES; i++) begin
         strobe_byte(random_byte());
      end
      hold_idle(3);
      @(negedge clk);
      assert (int'(level) == FIFO_BYTES)
         else report_mismatch($sformatf("level %0d with sink stalled", level));
      assert (int'(drop_count) == drops_before + BP_BYTES - FIFO_BYTES)
         else report_mismatch($sformatf("drop_count %0d with sink stalled", drop_count));
      words_before = delivered_total;
      set_take(1'b1);
      wait_for_drain(DRAIN_LIMIT);
      assert (delivered_total - words_before == FIFO_BYTES / WORD_BYTES)
         else report_mismatch($sformatf("%0d words after release",
                                        delivered_total - words_before));
   endtask

   // first half starves the sink so the fifo fills, second half mostly drains
   task automatic run_random();
      int take_pct;
      for (int i = 0; i < RAND_CYCLES; i++) begin
         take_pct = (i < RAND_CYCLES / 2) ? 10 : 70;
         @(posedge clk);
         byte_valid <= ($urandom % 100) < 55;
         byte_data  <= random_byte();
         word_take  <= ($urandom % 100) < take_pct;
      end
      hold_idle(3);
      set_take(1'b1);
      wait_for_drain(DRAIN_LIMIT);
      @(negedge clk);
      assert (int'(word_count) == delivered_total % (COUNT_MAX + 1))
         else report_mismatch($sformatf("word_count %0d after random run", word_count));
   endtask

   initial begin
      void'($urandom(32'h97333cc4));
      reset = 1'b1;
      byte_valid = 1'b0;
      byte_data = '0;
      word_take = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      check_after_reset();
      run_packing();
      run_back_pressure();
      run_random();
      $display("all tests passed");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      end_with_failure($sformatf("timeout: run did not finish within %0d clock cycles",
                                 WATCHDOG_CYCLES));
   end

endmodule
